// File: hw/alu_ops_pkg.sv
package alu_ops_pkg;

   localparam int XLEN = 32;  // Operand and result width

   // Codes follow the RV-style ALU operation table
   typedef enum logic [3:0] {
      ALU_AND  = 4'd0,
      ALU_OR   = 4'd1,
      ALU_ADD  = 4'd2,
      ALU_CNE  = 4'd3,
      ALU_SLL  = 4'd4,
      ALU_SUB  = 4'd5,
      ALU_SRL  = 4'd6,
      ALU_SRA  = 4'd7,
      ALU_SLT  = 4'd8,
      ALU_SLTU = 4'd9,
      ALU_XOR  = 4'd10,
      ALU_CGE  = 4'd11,
      ALU_CGEU = 4'd12,
      ALU_CE   = 4'd13
   } alu_op_t;

   // Operations whose result is a single 0/1 flag
   function automatic logic is_compare(alu_op_t op);
      return op inside {ALU_CNE, ALU_SLT, ALU_SLTU, ALU_CGE, ALU_CGEU, ALU_CE};
   endfunction

   // Operations that take their amount from b[4:0]
   function automatic logic is_shift(alu_op_t op);
      return op inside {ALU_SLL, ALU_SRL, ALU_SRA};
   endfunction

endpackage

// File: hw/alu_timing_pkg.sv
package alu_timing_pkg;

   // Bit position counter, one count per operand bit
   localparam int CNT_W = 5;

   // Start edge to done edge, identical for every operation
   localparam int ALU_LATENCY = 34;

   // Cycles between the last streamed bit and the end of busy.
   // One for the core register, one for the result register
   localparam int DRAIN_CYCLES = ALU_LATENCY - (1 << CNT_W);
   localparam int DRAIN_W      = 2;

endpackage

// File: hw/alu_stream_if.sv
// Operand bit stream, serializer to core
interface alu_bit_if import alu_ops_pkg::*; ();

   logic    bit_valid;  // One bit position this cycle
   logic    first;      // Bit 0
   logic    last;       // Bit XLEN-1
   logic    a_bit;      // Shifted source bit for shifts
   logic    b_bit;      // Zero for shifts
   alu_op_t op;         // Held for the whole request

   modport src (
      output bit_valid, first, last, a_bit, b_bit, op
   );

   modport dst (
      input  bit_valid, first, last, a_bit, b_bit, op
   );

endinterface

// Result bit stream, core to assembler
interface alu_res_if ();

   logic res_valid;  // Result bit present
   logic res_bit;
   logic res_last;   // Final bit of the request
   logic cmp_en;     // Request is a comparison
   logic cmp_bit;    // Comparison outcome, valid with res_last

   modport src (
      output res_valid, res_bit, res_last, cmp_en, cmp_bit
   );

   modport dst (
      input  res_valid, res_bit, res_last, cmp_en, cmp_bit
   );

endinterface

// File: hw/operand_serializer.sv
module operand_serializer import alu_ops_pkg::*, alu_timing_pkg::*; (
   input  logic            clk,
   input  logic            rst,
   input  logic            start,
   input  alu_op_t         op_in,
   input  logic [XLEN-1:0] a_in,
   input  logic [XLEN-1:0] b_in,
   output logic            busy,
   alu_bit_if.src          bits
);

   logic [XLEN-1:0]    a_q;
   logic [XLEN-1:0]    b_q;
   alu_op_t            op_q;
   logic               run;      // Streaming bit positions
   logic [CNT_W-1:0]   cnt;      // Current bit position
   logic [DRAIN_W-1:0] drain;    // Cycles left until busy falls
   logic [CNT_W-1:0]   shamt;
   logic [CNT_W:0]     up_idx;   // Source position for right shifts
   logic [CNT_W:0]     dn_idx;   // Source position for left shift
   logic               fill;
   logic               src_bit;
   logic               accept;

   assign accept = start && !busy;  // Start while busy is dropped
   assign shamt  = b_q[CNT_W-1:0];
   assign up_idx = {1'b0, cnt} + {1'b0, shamt};
   assign dn_idx = {1'b0, cnt} - {1'b0, shamt};
   assign fill   = (op_q == ALU_SRA) ? a_q[XLEN-1] : 1'b0;

   // Pick the operand bit that lands on position cnt
   always_comb begin
      case (op_q)
         ALU_SLL:          src_bit = dn_idx[CNT_W] ? 1'b0 : a_q[dn_idx[CNT_W-1:0]];
         ALU_SRL, ALU_SRA: src_bit = up_idx[CNT_W] ? fill : a_q[up_idx[CNT_W-1:0]];
         default:          src_bit = a_q[cnt];
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         busy           <= 1'b0;
         run            <= 1'b0;
         cnt            <= '0;
         drain          <= '0;
         bits.bit_valid <= 1'b0;
         bits.first     <= 1'b0;
         bits.last      <= 1'b0;
      end else begin
         bits.bit_valid <= run;
         bits.first     <= run && (cnt == '0);
         bits.last      <= run && (&cnt);
         if (!busy) begin
            if (start) begin
               busy <= 1'b1;
               run  <= 1'b1;
               cnt  <= '0;
            end
         end else if (run) begin
            cnt <= cnt + CNT_W'(1);
            if (&cnt) begin
               run   <= 1'b0;
               drain <= DRAIN_W'(DRAIN_CYCLES);
            end
         end else begin
            // Wait for the core and assembler stages to empty
            drain <= drain - DRAIN_W'(1);
            if (drain == DRAIN_W'(1)) begin
               busy <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         a_q  <= a_in;
         b_q  <= b_in;
         op_q <= op_in;
      end
      if (run) begin
         bits.a_bit <= src_bit;
         bits.b_bit <= is_shift(op_q) ? 1'b0 : b_q[cnt];  // Amount is not an operand
      end
   end

   assign bits.op = op_q;

endmodule

// File: hw/serial_alu_core.sv
module serial_alu_core import alu_ops_pkg::*; (
   input  logic   clk,
   input  logic   rst,
   alu_bit_if.dst bits,
   alu_res_if.src res
);

   logic carry;    // Carry into the next bit position
   logic eq_q;     // All bits so far equal
   logic lt_q;     // Low bits so far give a < b unsigned
   logic is_sub;
   logic b_eff;
   logic cin;
   logic sum;
   logic cout;
   logic eq_nxt;
   logic lt_nxt;
   logic slt;
   logic cmp_val;
   logic res_val;

   // Subtract as a + ~b + 1, the +1 enters as carry on bit 0
   assign is_sub = (bits.op == ALU_SUB);
   assign b_eff  = bits.b_bit ^ is_sub;
   assign cin    = bits.first ? is_sub : carry;
   assign sum    = bits.a_bit ^ b_eff ^ cin;
   assign cout   = (bits.a_bit & b_eff) | (cin & (bits.a_bit ^ b_eff));

   assign eq_nxt = (bits.first | eq_q) & (bits.a_bit ~^ bits.b_bit);

   // A higher differing bit overrides whatever the lower bits said
   assign lt_nxt = (~bits.a_bit & bits.b_bit)
                 | ((bits.a_bit ~^ bits.b_bit) & ~bits.first & lt_q);

   // On the sign bit, differing signs decide the signed order directly
   assign slt = (bits.a_bit ^ bits.b_bit) ? bits.a_bit : lt_nxt;

   always_comb begin
      case (bits.op)
         ALU_CE:   cmp_val = eq_nxt;
         ALU_CNE:  cmp_val = ~eq_nxt;
         ALU_SLT:  cmp_val = slt;
         ALU_SLTU: cmp_val = lt_nxt;
         ALU_CGE:  cmp_val = ~slt;
         ALU_CGEU: cmp_val = ~lt_nxt;
         default:  cmp_val = 1'b0;
      endcase
   end

   always_comb begin
      case (bits.op)
         ALU_AND:          res_val = bits.a_bit & bits.b_bit;
         ALU_OR:           res_val = bits.a_bit | bits.b_bit;
         ALU_XOR:          res_val = bits.a_bit ^ bits.b_bit;
         ALU_ADD, ALU_SUB: res_val = sum;
         ALU_SLL, ALU_SRL,
         ALU_SRA:          res_val = bits.a_bit;  // Already shifted upstream
         default:          res_val = 1'b0;        // Compares and unused codes
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         carry         <= 1'b0;
         eq_q          <= 1'b0;
         lt_q          <= 1'b0;
         res.res_valid <= 1'b0;
         res.res_last  <= 1'b0;
         res.cmp_en    <= 1'b0;
      end else begin
         res.res_valid <= bits.bit_valid;
         res.res_last  <= bits.bit_valid && bits.last;
         res.cmp_en    <= bits.bit_valid && is_compare(bits.op);
         if (bits.bit_valid) begin
            carry <= cout;
            eq_q  <= eq_nxt;
            lt_q  <= lt_nxt;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (bits.bit_valid) begin
         res.res_bit <= res_val;
         res.cmp_bit <= cmp_val;  // Only meaningful on the last bit
      end
   end

endmodule

// File: hw/result_assembler.sv
module result_assembler import alu_ops_pkg::*; (
   input  logic            clk,
   input  logic            rst,
   alu_res_if.dst          res,
   output logic            done,
   output logic [XLEN-1:0] result
);

   logic [XLEN-1:0] shreg;
   logic [XLEN-1:0] shreg_nxt;
   logic [XLEN-1:0] cmp_word;
   logic            finish;

   // New bits enter at the top, so bit 0 is lowest after XLEN shifts
   assign shreg_nxt = {res.res_bit, shreg[XLEN-1:1]};
   assign cmp_word  = {{(XLEN-1){1'b0}}, res.cmp_bit};
   assign finish    = res.res_valid && res.res_last;

   always_ff @(posedge clk) begin
      if (res.res_valid) begin
         shreg <= shreg_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         done   <= 1'b0;
         result <= '0;
      end else begin
         done <= finish;  // Single cycle, one per request
         if (finish) begin
            result <= res.cmp_en ? cmp_word : shreg_nxt;
         end
      end
   end

endmodule

// File: hw/serial_alu_top.sv
module serial_alu_top import alu_ops_pkg::*; (
   input  logic            clk,
   input  logic            rst,
   input  logic            start,
   input  alu_op_t         op,
   input  logic [XLEN-1:0] a,
   input  logic [XLEN-1:0] b,
   output logic            busy,
   output logic            done,
   output logic [XLEN-1:0] result
);

   alu_bit_if bit_bus ();
   alu_res_if res_bus ();

   operand_serializer operand_serializer_inst (
      .clk   (clk),
      .rst   (rst),
      .start (start),
      .op_in (op),
      .a_in  (a),
      .b_in  (b),
      .busy  (busy),
      .bits  (bit_bus.src)
   );

   serial_alu_core serial_alu_core_inst (
      .clk  (clk),
      .rst  (rst),
      .bits (bit_bus.dst),
      .res  (res_bus.src)
   );

   result_assembler result_assembler_inst (
      .clk    (clk),
      .rst    (rst),
      .res    (res_bus.dst),
      .done   (done),
      .result (result)
   );

endmodule

// File: test/serial_alu_asserts.sv
module serial_alu_asserts import alu_timing_pkg::*; (
   input logic clk,
   input logic rst,
   input logic start,
   input logic busy,
   input logic done
);

   logic accepted;

   assign accepted = start && !busy;  // Start taken while idle

   done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
      else $error("done stayed high for more than one cycle");

   // Done is registered on the latency edge and sampled one edge after it
   done_after_start: assert property (@(posedge clk) disable iff (rst)
      $past(accepted, ALU_LATENCY + 1) |-> done)
      else $error("done missing at the fixed latency after an accepted start");

   done_has_start: assert property (@(posedge clk) disable iff (rst)
      done |-> $past(accepted, ALU_LATENCY + 1))
      else $error("done raised without an accepted start at the fixed latency");

   busy_clear: assert property (@(posedge clk) disable iff (rst) done |-> !busy)
      else $error("busy still high while done is high");

   reset_quiet: assert property (@(posedge clk) $fell(rst) |-> !done && !busy)
      else $error("done or busy high right after reset");

endmodule

bind serial_alu_top serial_alu_asserts serial_alu_asserts_inst (
   .clk   (clk),
   .rst   (rst),
   .start (start),
   .busy  (busy),
   .done  (done)
);

// File: test/serial_alu_tb.sv
module serial_alu_tb import alu_ops_pkg::*, alu_timing_pkg::*; ();

   localparam int MAX_RECORDS = 64;
   localparam int MEM_WORDS   = 1 + 4 * MAX_RECORDS;  // Count word, then 4 words per record
   localparam int WAIT_LIMIT  = 2 * ALU_LATENCY;

   logic            clk;
   logic            rst;
   logic            start;
   alu_op_t         op;
   logic [XLEN-1:0] a;
   logic [XLEN-1:0] b;
   logic            busy;
   logic            done;
   logic [XLEN-1:0] result;

   logic [31:0]     pat_mem [0:MEM_WORDS-1];
   logic [31:0]     lfsr;
   logic [XLEN-1:0] prev_result;  // Output value held between done pulses
   int              errors;
   int              tests_run;
   int              tests_failed;

   serial_alu_top serial_alu_top_inst (
      .clk    (clk),
      .rst    (rst),
      .start  (start),
      .op     (op),
      .a      (a),
      .b      (b),
      .busy   (busy),
      .done   (done),
      .result (result)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // Drive and sample point, 2 units past the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic report_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
      $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
      errors++;
   endtask

   task automatic run_request(input int idx, input alu_op_t req_op, input logic [XLEN-1:0] req_a,
                              input logic [XLEN-1:0] req_b, input logic [XLEN-1:0] expected,
                              input bit inject);
      int cycles;
      bit seen;
      int errors_before;
      errors_before = errors;
      op    = req_op;
      a     = req_a;
      b     = req_b;
      start = 1'b1;
      next_cycle();  // Edge 0 has taken the start
      start  = 1'b0;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < WAIT_LIMIT) begin
         next_cycle();
         cycles++;
         // Stray starts mid-stream and on the edge that raises done
         start = inject && (cycles == 5 || cycles == ALU_LATENCY - 1);
         if (start) begin
            op = ALU_OR;
            a  = ~req_a;
            b  = ~req_b;
         end
         if (done) begin
            seen = 1'b1;
         end else begin
            assert (result == prev_result) else report_value("result", prev_result, result);
            assert (busy) else report_value("busy", XLEN'(1'b1), XLEN'(busy));
         end
      end
      start = 1'b0;
      if (!seen) begin
         $display("Test %0d: done did not arrive within %0d cycles", idx, WAIT_LIMIT);
         errors++;
      end else begin
         assert (cycles == ALU_LATENCY) else report_value("done latency", ALU_LATENCY, cycles);
         assert (result == expected) else report_value("result", expected, result);
         assert (!busy) else report_value("busy", '0, XLEN'(busy));
         prev_result = expected;
      end
      tests_run++;
      if (errors != errors_before) begin
         tests_failed++;
      end
      $display("Test %0d %s a=%h b=%h result=%h %s", idx, req_op.name(), req_a, req_b,
               result, (errors == errors_before) ? "ok" : "failed");
   endtask

   initial begin
      int count;
      int gap;
      int base;
      int i;
      rst          = 1'b1;
      start        = 1'b0;
      op           = ALU_AND;
      a            = '0;
      b            = '0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      prev_result  = '0;
      lfsr         = 32'h07b2821c;
      $readmemh("test/alu_patterns.hex", pat_mem);
      count = int'(pat_mem[0]);
      repeat (4) @(posedge clk);
      #2;
      rst = 1'b0;

      assert (!done) else report_value("done", '0, XLEN'(done));
      assert (!busy) else report_value("busy", '0, XLEN'(busy));
      assert (result == '0) else report_value("result", '0, result);
      if (count < 1 || count > MAX_RECORDS) begin
         $display("Pattern file holds an invalid record count of %0d", count);
         errors++;
         count = 0;
      end

      for (i = 0; i < count; i++) begin
         base = 1 + 4 * i;
         lfsr = lfsr_step(lfsr);
         gap  = int'(lfsr[0]);
         lfsr = lfsr_step(lfsr);
         gap  = gap + 2 * int'(lfsr[0]);  // Idle gap of 0 to 3 cycles
         repeat (gap) next_cycle();
         run_request(i, alu_op_t'(pat_mem[base][3:0]), pat_mem[base+1], pat_mem[base+2],
                     pat_mem[base+3], (i % 3) == 2);
      end

      $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
               tests_run, tests_run - tests_failed, tests_failed, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: src.f
hw/alu_ops_pkg.sv
hw/alu_timing_pkg.sv
hw/alu_stream_if.sv
hw/operand_serializer.sv
hw/serial_alu_core.sv
hw/result_assembler.sv
hw/serial_alu_top.sv
test/serial_alu_asserts.sv
test/serial_alu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the serial ALU testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
   --top-module serial_alu_tb \
   -f src.f \
   -o serial_alu_sim

status=0
./obj_dir/serial_alu_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
   echo "Simulator exited with status $status"
   exit 1
fi
if grep -q "FAIL: see errors above" sim.log; then
   exit 1
fi
exit 0

// File: test/alu_patterns.hex
// First word is the record count, then one record per line
// Columns: operation code, operand a, operand b, expected result
00000027
0 F0F0F0F0 FF00FF00 F000F000
0 FFFFFFFF 12345678 12345678
1 F0F0F0F0 0F0F0000 FFFFF0F0
A AAAA5555 FFFF0000 55555555
2 FFFFFFFF 00000001 00000000
2 12345678 11111111 23456789
2 7FFFFFFF 00000001 80000000
5 00000000 00000001 FFFFFFFF
5 80000000 00000001 7FFFFFFF
5 23456789 12345678 11111111
4 00000001 00000000 00000001
4 00000001 0000001F 80000000
4 12345678 FFFFFFE4 23456780
6 80000000 0000001F 00000001
6 12345678 00000008 00123456
6 87654321 00000024 08765432
7 80000000 0000001F FFFFFFFF
7 F0000000 00000004 FF000000
7 70000000 00000004 07000000
7 87654321 00000000 87654321
D 12345678 12345678 00000001
D 12345678 12345679 00000000
D 80000001 00000001 00000000
3 12345678 12345679 00000001
3 12345678 12345678 00000000
8 FFFFFFFF 00000001 00000001
9 FFFFFFFF 00000001 00000000
8 00000001 FFFFFFFF 00000000
9 00000001 FFFFFFFF 00000001
8 00000005 00000005 00000000
9 00000005 00000005 00000000
8 FFFFFFFE FFFFFFFF 00000001
B 80000000 7FFFFFFF 00000000
C 80000000 7FFFFFFF 00000001
B 00000005 00000005 00000001
C 00000005 00000005 00000001
B FFFFFFFE FFFFFFFF 00000000
9 00000010 00000100 00000001
C 00000100 00000010 00000001
